/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary -Wno-fatal
TOP       = paillier_top_tb
FILELIST  = paillier_top.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* logic/mod_exp.sv */
`default_nettype none

// Left-to-right square-and-multiply over all K exponent bits
module mod_exp import paillier_pkg::*; #(
    parameter int             K       = DEFAULT_K,
    parameter logic [K-1:0]   MODULUS = DEFAULT_MODULUS
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  logic [K-1:0] base,
    input  logic [K-1:0] exponent,
    output logic         done,
    output logic [K-1:0] power
);

    localparam int BW = $clog2(K);

    exp_state_t    state;
    logic [K-1:0]  base_q;
    logic [K-1:0]  exp_q;
    logic [K-1:0]  acc;
    logic [BW-1:0] bit_idx;
    logic          launch;

    logic          mul_start;
    logic [K-1:0]  mul_a;
    logic [K-1:0]  mul_b;
    logic          mul_done;
    logic [K-1:0]  mul_product;

    logic          last_bit;
    logic          next_sq;
    logic          next_mul;

    assign last_bit = (bit_idx == '0);

    // Next product is chained straight off the done pulse
    // so each product costs K+2 cycles
    assign next_mul = (state == EX_SQUARE) && mul_done && exp_q[bit_idx];
    assign next_sq  = mul_done && !last_bit &&
                      (((state == EX_SQUARE) && !exp_q[bit_idx]) ||
                       (state == EX_MULTIPLY));

    assign mul_start = launch || next_sq || next_mul;
    // First squaring works on acc = 1, later ones on the fresh product
    assign mul_a     = launch ? acc : mul_product;
    assign mul_b     = next_mul ? base_q : mul_a;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= EX_IDLE;
            launch  <= 1'b0;
            bit_idx <= '0;
        end else begin
            launch <= 1'b0;
            case (state)
                EX_IDLE: begin
                    if (start) begin
                        launch  <= 1'b1;
                        bit_idx <= BW'(K - 1);
                        state   <= EX_SQUARE;
                    end
                end
                EX_SQUARE: begin
                    if (mul_done) begin
                        if (exp_q[bit_idx]) begin
                            state <= EX_MULTIPLY;
                        end else if (last_bit) begin
                            state <= EX_DONE;
                        end else begin
                            bit_idx <= bit_idx - 1'b1;
                        end
                    end
                end
                EX_MULTIPLY: begin
                    if (mul_done) begin
                        if (last_bit) begin
                            state <= EX_DONE;
                        end else begin
                            bit_idx <= bit_idx - 1'b1;
                            state   <= EX_SQUARE;
                        end
                    end
                end
                default: begin
                    state <= EX_IDLE;
                end
            endcase
        end
    end

    // Operands and running power
    always_ff @(posedge clk) begin
        if (state == EX_IDLE && start) begin
            base_q <= base;
            exp_q  <= exponent;
            acc    <= K'(1);
        end else if (mul_done) begin
            acc <= mul_product;
        end
    end

    assign done  = (state == EX_DONE);
    assign power = acc;

    mod_mul #(
        .K       (K),
        .MODULUS (MODULUS)
    ) mod_mul_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mul_start),
        .a       (mul_a),
        .b       (mul_b),
        .done    (mul_done),
        .product (mul_product)
    );

endmodule

`default_nettype wire

/* logic/mod_mul.sv */
`default_nettype none

// Interleaved modular multiplier, one bit of b per cycle starting at the MSB
module mod_mul import paillier_pkg::*; #(
    parameter int             K       = DEFAULT_K,
    parameter logic [K-1:0]   MODULUS = DEFAULT_MODULUS
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  logic [K-1:0] a,
    input  logic [K-1:0] b,
    output logic         done,
    output logic [K-1:0] product
);

    localparam int CW = $clog2(K);
    localparam logic [K:0] MOD_EXT = {1'b0, MODULUS};

    logic [K-1:0]  a_q;
    logic [K-1:0]  b_q;
    logic [K-1:0]  acc;
    logic [CW-1:0] cnt;
    logic          busy;
    logic          fin;

    logic [K:0]    sum;
    logic [K:0]    red1;
    logic [K:0]    red2;

    // acc < M, so 2*acc + a < 3*M and two subtractions bring it back below M
    always_comb begin
        sum  = {acc, 1'b0} + (b_q[K-1] ? {1'b0, a_q} : '0);
        red1 = (sum >= MOD_EXT) ? sum - MOD_EXT : sum;
        red2 = (red1 >= MOD_EXT) ? red1 - MOD_EXT : red1;
    end

    // Bit counter and done sequencing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            fin  <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= fin;
            fin  <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                // Last bit step, done follows one cycle later
                if (cnt == CW'(K - 1)) begin
                    busy <= 1'b0;
                    fin  <= 1'b1;
                end
            end
        end
    end

    // Operand and accumulator datapath
    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= a;
            b_q <= b;
            acc <= '0;
        end else if (busy) begin
            acc <= red2[K-1:0];
            b_q <= {b_q[K-2:0], 1'b0};
        end
    end

    // Accumulator holds its value after the last step
    assign product = acc;

endmodule

`default_nettype wire

/* logic/paillier_pkg.sv */
`default_nettype none

package paillier_pkg;

    // Command opcodes on the ciphertext domain
    typedef enum logic {
        OP_HOMO_ADD   = 1'b0,
        OP_SCALAR_MUL = 1'b1
    } op_t;

    // Task controller states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_ADD_RUN = 2'd1,
        ST_MUL_RUN = 2'd2,
        ST_RESULT  = 2'd3
    } ctrl_state_t;

    // Exponentiator states, one square and an optional multiply per bit
    typedef enum logic [1:0] {
        EX_IDLE     = 2'd0,
        EX_SQUARE   = 2'd1,
        EX_MULTIPLY = 2'd2,
        EX_DONE     = 2'd3
    } exp_state_t;

    // Ciphertext word width
    localparam int DEFAULT_K = 64;

    // n^2 with n = 65521 * 32749, an odd 62-bit value
    // Kept below 2^(K-2) so 2*acc + a still fits in K+1 bits
    localparam logic [DEFAULT_K-1:0] DEFAULT_MODULUS = 64'h3FE5_83DB_0500_3D49;

endpackage

`default_nettype wire

/* logic/paillier_top.sv */
`default_nettype none

// Paillier ciphertext coprocessor
// Homomorphic add is c1*c2 mod n^2, scalar multiply is c^k mod n^2
module paillier_top import paillier_pkg::*; #(
    parameter int           K       = DEFAULT_K,
    parameter logic [K-1:0] MODULUS = DEFAULT_MODULUS
) (
    input  logic         clk,
    input  logic         rst_n,

    input  logic         cmd_valid,
    output logic         cmd_ready,
    input  op_t          cmd_op,
    input  logic [K-1:0] operand_a,
    input  logic [K-1:0] operand_b,

    output logic         result_valid,
    output logic [K-1:0] result,
    input  logic         result_ready
);

    logic         mul_start;
    logic         exp_start;
    logic [K-1:0] unit_a;
    logic [K-1:0] unit_b;
    logic         mul_done;
    logic [K-1:0] mul_product;
    logic         exp_done;
    logic [K-1:0] exp_power;

    task_ctrl #(
        .K            (K)
    ) task_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_op       (cmd_op),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .mul_start    (mul_start),
        .exp_start    (exp_start),
        .unit_a       (unit_a),
        .unit_b       (unit_b),
        .mul_done     (mul_done),
        .mul_product  (mul_product),
        .exp_done     (exp_done),
        .exp_power    (exp_power),
        .result_valid (result_valid),
        .result       (result),
        .result_ready (result_ready)
    );

    // Homomorphic add unit
    mod_mul #(
        .K       (K),
        .MODULUS (MODULUS)
    ) mod_mul_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mul_start),
        .a       (unit_a),
        .b       (unit_b),
        .done    (mul_done),
        .product (mul_product)
    );

    // Scalar multiply unit, operand b is the exponent
    mod_exp #(
        .K        (K),
        .MODULUS  (MODULUS)
    ) mod_exp_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (exp_start),
        .base     (unit_a),
        .exponent (unit_b),
        .done     (exp_done),
        .power    (exp_power)
    );

endmodule

`default_nettype wire

/* logic/task_ctrl.sv */
`default_nettype none

// Command dispatch to the multiplier or the exponentiator, one task at a time
module task_ctrl import paillier_pkg::*; #(
    parameter int K = DEFAULT_K
) (
    input  logic         clk,
    input  logic         rst_n,

    input  logic         cmd_valid,
    output logic         cmd_ready,
    input  op_t          cmd_op,
    input  logic [K-1:0] operand_a,
    input  logic [K-1:0] operand_b,

    output logic         mul_start,
    output logic         exp_start,
    output logic [K-1:0] unit_a,
    output logic [K-1:0] unit_b,

    input  logic         mul_done,
    input  logic [K-1:0] mul_product,
    input  logic         exp_done,
    input  logic [K-1:0] exp_power,

    output logic         result_valid,
    output logic [K-1:0] result,
    input  logic         result_ready
);

    ctrl_state_t state;
    logic        cmd_fire;
    logic        unit_done;
    logic [K-1:0] unit_result;

    assign cmd_ready    = (state == ST_IDLE);
    assign result_valid = (state == ST_RESULT);
    assign cmd_fire     = cmd_valid && cmd_ready;

    // Pick the done and result of whichever unit the task is running on
    assign unit_done   = (state == ST_ADD_RUN) ? mul_done : exp_done;
    assign unit_result = (state == ST_ADD_RUN) ? mul_product : exp_power;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            mul_start <= 1'b0;
            exp_start <= 1'b0;
        end else begin
            // Starts are single-cycle, raised the cycle after the command edge
            mul_start <= cmd_fire && (cmd_op == OP_HOMO_ADD);
            exp_start <= cmd_fire && (cmd_op == OP_SCALAR_MUL);
            case (state)
                ST_IDLE: begin
                    if (cmd_fire) begin
                        state <= (cmd_op == OP_HOMO_ADD) ? ST_ADD_RUN : ST_MUL_RUN;
                    end
                end
                ST_ADD_RUN, ST_MUL_RUN: begin
                    if (unit_done) begin
                        state <= ST_RESULT;
                    end
                end
                ST_RESULT: begin
                    // Hold the result until the consumer takes it
                    if (result_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Operand capture on accept, result capture on unit done
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            unit_a <= operand_a;
            unit_b <= operand_b;
        end
        if ((state == ST_ADD_RUN || state == ST_MUL_RUN) && unit_done) begin
            result <= unit_result;
        end
    end

endmodule

`default_nettype wire

/* paillier_top.f */
logic/paillier_pkg.sv
logic/mod_mul.sv
logic/mod_exp.sv
logic/task_ctrl.sv
logic/paillier_top.sv
tests/paillier_top_tb.sv

/* tests/paillier_cases.txt */
# Paillier coprocessor cases, all values in hex
# op (0 homomorphic add, 1 scalar multiply)  operand_a  operand_b  expected result
0 0000000000000003 0000000000000005 000000000000000f
0 0000000000000000 1234567890abcdef 0000000000000000
0 0000000000000001 1234567890abcdef 1234567890abcdef
0 1234567890abcdef 0000000000000001 1234567890abcdef
0 3fe583db05003d48 3fe583db05003d48 0000000000000001
0 3fe583db05003d48 0000000000000002 3fe583db05003d47
0 0000000000000005 3fe583db05003d48 3fe583db05003d44
0 3fe583db05003d48 0000000000001234 3fe583db05002b15
0 00000000ffffffff 00000000ffffffff 0069f091ebff0add
0 0000000100000000 0000000100000000 0069f093ebff0adc
0 0000000080000000 0000000040000000 2000000000000000
0 0000000080000000 0000000080000000 001a7c24faffc2b7
0 00000000cfd41b91 00000000cfd41b91 28edac9c1f1f6d8f
1 1234567890abcdef 0000000000000000 0000000000000001
1 1234567890abcdef 0000000000000001 1234567890abcdef
1 3fe583db05003d48 ffffffffffffffff 3fe583db05003d48
1 0000000000000001 ffffffffffffffff 0000000000000001
1 0000000000000000 0000000000000005 0000000000000000
1 0000000000000000 0000000000000000 0000000000000001
1 0000000000000002 000000000000003d 2000000000000000
1 0000000000000002 000000000000003e 001a7c24faffc2b7
1 0000000000000002 000000000000003f 0034f849f5ff856e
1 0000000000000002 0000000000000040 0069f093ebff0adc
1 0000000000000002 0000000000000041 00d3e127d7fe15b8
1 0000000000000003 0000000000000014 00000000cfd41b91
1 0000000000000003 0000000000000028 28edac9c1f1f6d8f
1 3fe583db05003d48 0000000000000002 0000000000000001
1 3fe583db05003d48 8000000000000000 0000000000000001

/* tests/paillier_top_tb.sv */
`default_nettype none

// Drives the coprocessor with the cases in tests/paillier_cases.txt
module paillier_top_tb import paillier_pkg::*; ();

    localparam int           K         = DEFAULT_K;
    localparam logic [K-1:0] MODULUS   = DEFAULT_MODULUS;
    localparam int           MAX_CASES = 64;

    logic         clk;
    logic         rst_n;
    logic         cmd_valid;
    logic         cmd_ready;
    op_t          cmd_op;
    logic [K-1:0] operand_a;
    logic [K-1:0] operand_b;
    logic         result_valid;
    logic [K-1:0] result;
    logic         result_ready;

    op_t          case_op  [MAX_CASES];
    logic [K-1:0] case_a   [MAX_CASES];
    logic [K-1:0] case_b   [MAX_CASES];
    logic [K-1:0] case_exp [MAX_CASES];
    int           n_cases;
    logic         loaded;

    // Accepted commands still waiting for their result
    int           pend_idx [$];
    int           pend_cyc [$];

    int           cyc;
    int           n_results;
    int           value_errors;
    int           protocol_errors;
    logic [31:0]  rng;
    logic         prev_valid;
    logic         prev_ready;
    logic [K-1:0] held_result;

    paillier_top paillier_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_op       (cmd_op),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .result_valid (result_valid),
        .result       (result),
        .result_ready (result_ready)
    );

    always #4 clk = ~clk;

    // Free-running cycle count for latency checks
    always @(negedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Reference product with full 128-bit intermediate
    function automatic logic [K-1:0] mulmod(input logic [K-1:0] x, input logic [K-1:0] y);
        logic [2*K-1:0] p;
        logic [2*K-1:0] r;
        p = {{K{1'b0}}, x} * {{K{1'b0}}, y};
        r = p % {{K{1'b0}}, MODULUS};
        return r[K-1:0];
    endfunction

    function automatic logic [K-1:0] powmod(input logic [K-1:0] x, input logic [K-1:0] e);
        logic [K-1:0] r;
        r = K'(1);
        for (int i = K - 1; i >= 0; i--) begin
            r = mulmod(r, r);
            if (e[i]) begin
                r = mulmod(r, x);
            end
        end
        return r;
    endfunction

    task automatic load_cases();
        int           fd;
        int           n;
        string        line;
        logic [3:0]   op_val;
        logic [K-1:0] a_val;
        logic [K-1:0] b_val;
        logic [K-1:0] e_val;
        n_cases = 0;
        fd = $fopen("tests/paillier_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/paillier_cases.txt");
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = "";
            void'($fgets(line, fd));
            // Comment lines start with a hash
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h", op_val, a_val, b_val, e_val);
                if (n == 4) begin
                    case_op[n_cases]  = op_t'(op_val[0]);
                    case_a[n_cases]   = a_val;
                    case_b[n_cases]   = b_val;
                    case_exp[n_cases] = e_val;
                    n_cases++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic send_command(input int idx);
        // Short idle gap before some commands
        cmd_valid = 1'b0;
        repeat (idx % 3) @(negedge clk);
        cmd_valid = 1'b1;
        cmd_op    = case_op[idx];
        operand_a = case_a[idx];
        operand_b = case_b[idx];
        while (!cmd_ready) @(negedge clk);
        // Command edge has passed
        @(negedge clk);
        pend_idx.push_back(idx);
        pend_cyc.push_back(cyc);
        cmd_valid = 1'b0;
    endtask

    task automatic check_result(input int idx, input int fire_cyc);
        logic [K-1:0] model;
        if (case_op[idx] == OP_HOMO_ADD) begin
            model = mulmod(case_a[idx], case_b[idx]);
        end else begin
            model = powmod(case_a[idx], case_b[idx]);
        end
        if (result !== case_exp[idx]) begin
            $display("Fail result case %0d: expected %h got %h", idx, case_exp[idx], result);
            value_errors++;
        end
        if (result !== model) begin
            $display("Fail result case %0d: model %h got %h", idx, model, result);
            value_errors++;
        end
        if (case_op[idx] == OP_HOMO_ADD && cyc - fire_cyc != K + 3) begin
            $display("Case %0d add result came %0d cycles after the command, not %0d",
                     idx, cyc - fire_cyc, K + 3);
            protocol_errors++;
        end
    endtask

    task automatic monitor_results();
        int idx;
        int fire_cyc;
        forever begin
            @(negedge clk);
            if (result_valid && cmd_ready) begin
                $display("cmd_ready is high while a result is waiting");
                protocol_errors++;
            end
            if (prev_valid && !prev_ready) begin
                // Held under back-pressure
                if (!result_valid) begin
                    $display("result_valid dropped before the result was taken");
                    protocol_errors++;
                end else if (result !== held_result) begin
                    $display("Fail result held: expected %h got %h", held_result, result);
                    value_errors++;
                end
            end else if (prev_valid && prev_ready) begin
                n_results++;
                if (result_valid) begin
                    $display("result_valid still high after the result was taken");
                    protocol_errors++;
                end
            end else if (result_valid) begin
                if (pend_idx.size() == 0) begin
                    $display("A result appeared with no command pending");
                    protocol_errors++;
                end else begin
                    idx      = pend_idx.pop_front();
                    fire_cyc = pend_cyc.pop_front();
                    check_result(idx, fire_cyc);
                end
                held_result = result;
            end
            // Ready about three cycles in four
            rng          = xorshift32(rng);
            result_ready = (rng[1:0] != 2'b00);
            prev_ready   = result_ready;
            prev_valid   = result_valid;
        end
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        cmd_valid       = 1'b0;
        cmd_op          = OP_HOMO_ADD;
        operand_a       = '0;
        operand_b       = '0;
        result_ready    = 1'b0;
        n_results       = 0;
        value_errors    = 0;
        protocol_errors = 0;
        rng             = 32'h21f1;
        prev_valid      = 1'b0;
        prev_ready      = 1'b0;
        held_result     = '0;
        loaded          = 1'b0;
        load_cases();
        loaded = 1'b1;
        if (n_cases == 0) begin
            $display("No test cases were read from the case file");
            protocol_errors++;
        end
        repeat (10) begin
            @(negedge clk);
            if (result_valid !== 1'b0) begin
                $display("result_valid is not low during reset");
                protocol_errors++;
            end
        end
        rst_n = 1'b1;
        fork
            monitor_results();
        join_none
        @(negedge clk);
        if (cmd_ready !== 1'b1 || result_valid !== 1'b0) begin
            $display("Handshake outputs are wrong on the first cycle after reset");
            protocol_errors++;
        end
        for (int i = 0; i < n_cases; i++) begin
            send_command(i);
        end
        wait (n_results == n_cases);
        // Quiet period to catch any extra result
        repeat (K + 10) @(negedge clk);
        $display("Results %0d of %0d, value errors %0d, protocol errors %0d",
                 n_results, n_cases, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Worst case per command is 2K products of K+2 cycles plus handshake slack
    initial begin
        time limit;
        wait (loaded);
        limit = (time'(n_cases) * time'(2 * K * (K + 2) + K + 20) + time'(K + 60)) * 8;
        #(limit);
        $display("Timeout, the DUT did not finish all cases in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
